// File: src/ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

////////////////////
// Datapath
////////////////////

`define EX_XLEN 32

////////////////////
// Register file
////////////////////

// Architectural registers, x0 included
`define EX_NREGS 32
`define EX_RIDX_W 5

`endif

// File: src/ex_pkg.sv
package ex_pkg;

    // Integer ALU operations
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA
    } alu_op_e;

    // Instruction class as seen by the issue stage
    typedef enum logic {
        OP_ALU,
        OP_MUL
    } op_type_e;

    // FU_ALU means the stage already holds its data
    typedef enum logic {
        FU_ALU,
        FU_MUL
    } func_unit_e;

endpackage

// File: src/alu.sv
`timescale 1ns/100ps
`include "ex_config.svh"

module alu (
    input  ex_pkg::alu_op_e     i_op,
    input  logic [`EX_XLEN-1:0] i_a,
    input  logic [`EX_XLEN-1:0] i_b,
    output logic [`EX_XLEN-1:0] o_result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt = i_b[4:0];
    assign lt_signed = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb begin
        unique case (i_op)
            ex_pkg::ADD: o_result = i_a + i_b;
            ex_pkg::SUB: o_result = i_a - i_b;
            ex_pkg::AND: o_result = i_a & i_b;
            ex_pkg::OR:  o_result = i_a | i_b;
            ex_pkg::XOR: o_result = i_a ^ i_b;
            // Comparisons return 0 or 1
            ex_pkg::SLT: o_result = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            ex_pkg::SLTU: o_result = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            ex_pkg::SLL: o_result = i_a << shamt;
            ex_pkg::SRL: o_result = i_a >> shamt;
            // Arithmetic shift keeps the sign bit
            ex_pkg::SRA: o_result = $unsigned($signed(i_a) >>> shamt);
            default: o_result = '0;
        endcase
    end

endmodule

// File: src/mul_unit.sv
`timescale 1ns/100ps
`include "ex_config.svh"

module mul_unit (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                i_start,
    input  logic [`EX_XLEN-1:0] i_a,
    input  logic [`EX_XLEN-1:0] i_b,
    output logic                o_ready,
    output logic                o_valid,
    output logic [`EX_XLEN-1:0] o_product
);

    logic                busy_q;
    logic                valid_q;
    logic [`EX_XLEN-1:0] mcand_q;
    logic [`EX_XLEN-1:0] mplier_q;
    logic [`EX_XLEN-1:0] acc_q;
    logic [`EX_XLEN-1:0] acc_next;
    logic                last_step;

    // Add the shifted multiplicand when the current multiplier bit is set
    assign acc_next = mplier_q[0] ? acc_q + mcand_q : acc_q;

    // No set bits remain above the current one
    assign last_step = mplier_q[`EX_XLEN-1:1] == '0;

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            valid_q <= 1'b0;
        end else if (i_start) begin
            busy_q <= 1'b1;
            valid_q <= 1'b0;
        end else if (busy_q && last_step) begin
            busy_q <= 1'b0;
            valid_q <= 1'b1;
        end
    end

    ////////////////////
    // Datapath
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (i_start) begin
            mcand_q <= i_a;
            mplier_q <= i_b;
            acc_q <= '0;
        end else if (busy_q) begin
            acc_q <= acc_next;
            mcand_q <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign o_ready = !busy_q;
    assign o_valid = valid_q;
    // Only the low word is kept
    assign o_product = acc_q;

endmodule

// File: src/reg_file.sv
`timescale 1ns/100ps
`include "ex_config.svh"

module reg_file (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [`EX_RIDX_W-1:0] i_ra_sel,
    input  logic [`EX_RIDX_W-1:0] i_rb_sel,
    output logic [`EX_XLEN-1:0]   o_ra_data,
    output logic [`EX_XLEN-1:0]   o_rb_data,
    input  logic                  i_w_en,
    input  logic [`EX_RIDX_W-1:0] i_w_sel,
    input  logic [`EX_XLEN-1:0]   i_w_data
);

    logic [`EX_XLEN-1:0] regs_q [`EX_NREGS];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `EX_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_w_en && i_w_sel != '0) begin
            regs_q[i_w_sel] <= i_w_data;
        end
    end

    // x0 is hardwired to zero
    assign o_ra_data = (i_ra_sel == '0) ? '0 : regs_q[i_ra_sel];
    assign o_rb_data = (i_rb_sel == '0) ? '0 : regs_q[i_rb_sel];

endmodule

// File: src/issue_stage.sv
`timescale 1ns/100ps
`include "ex_config.svh"

module issue_stage (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Upstream
    input  logic                   i_valid,
    output logic                   o_ready,
    input  ex_pkg::op_type_e       i_op_type,
    input  ex_pkg::alu_op_e        i_alu_op,
    input  logic [`EX_RIDX_W-1:0]  i_rd,
    input  logic [`EX_RIDX_W-1:0]  i_rs1,
    input  logic [`EX_RIDX_W-1:0]  i_rs2,
    input  logic                   i_use_imm,
    input  logic [`EX_XLEN-1:0]    i_imm,
    // Register file
    output logic [`EX_RIDX_W-1:0]  o_ra_sel,
    output logic [`EX_RIDX_W-1:0]  o_rb_sel,
    input  logic [`EX_XLEN-1:0]    i_ra_data,
    input  logic [`EX_XLEN-1:0]    i_rb_data,
    // Bypass
    input  logic                   i_ex1_pending,
    input  logic [`EX_RIDX_W-1:0]  i_ex1_rd,
    input  logic                   i_ex1_data_valid,
    input  logic [`EX_XLEN-1:0]    i_ex1_data,
    input  logic                   i_ex2_pending,
    input  logic [`EX_RIDX_W-1:0]  i_ex2_rd,
    input  logic                   i_ex2_data_valid,
    input  logic [`EX_XLEN-1:0]    i_ex2_data,
    // Multiplier
    input  logic                   i_mul_ready,
    output logic                   o_mul_start,
    output logic [`EX_XLEN-1:0]    o_mul_a,
    output logic [`EX_XLEN-1:0]    o_mul_b,
    // Result stages
    input  logic                   i_ex1_ready,
    output logic                   o_issue,
    output ex_pkg::func_unit_e     o_issue_unit,
    output logic [`EX_RIDX_W-1:0]  o_issue_rd,
    output logic [`EX_XLEN-1:0]    o_issue_data
);

    logic                  hold_valid_q;
    ex_pkg::op_type_e      hold_op_type_q;
    ex_pkg::alu_op_e       hold_alu_op_q;
    logic [`EX_RIDX_W-1:0] hold_rd_q;
    logic [`EX_RIDX_W-1:0] hold_rs1_q;
    logic [`EX_RIDX_W-1:0] hold_rs2_q;
    logic                  hold_use_imm_q;
    logic [`EX_XLEN-1:0]   hold_imm_q;

    logic                  rs1_ex1, rs1_ex2, rs2_ex1, rs2_ex2;
    logic                  rs1_stall, rs2_stall;
    logic                  is_mul;
    logic [`EX_XLEN-1:0]   rs1_val, rs2_val, op_b;

    ////////////////////
    // Holding register
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hold_valid_q <= 1'b0;
        end else if (i_valid && o_ready) begin
            hold_valid_q <= 1'b1;
        end else if (o_issue) begin
            hold_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (i_valid && o_ready) begin
            hold_op_type_q <= i_op_type;
            hold_alu_op_q <= i_alu_op;
            hold_rd_q <= i_rd;
            hold_rs1_q <= i_rs1;
            hold_rs2_q <= i_rs2;
            hold_use_imm_q <= i_use_imm;
            hold_imm_q <= i_imm;
        end
    end

    assign o_ra_sel = hold_rs1_q;
    assign o_rb_sel = hold_rs2_q;

    ////////////////////
    // Bypass and hazards
    ////////////////////

    // EX1 holds the younger result and wins over EX2
    assign rs1_ex1 = i_ex1_pending && hold_rs1_q != '0 && i_ex1_rd == hold_rs1_q;
    assign rs1_ex2 = i_ex2_pending && hold_rs1_q != '0 && i_ex2_rd == hold_rs1_q;
    assign rs2_ex1 = i_ex1_pending && hold_rs2_q != '0 && i_ex1_rd == hold_rs2_q;
    assign rs2_ex2 = i_ex2_pending && hold_rs2_q != '0 && i_ex2_rd == hold_rs2_q;

    assign rs1_val = rs1_ex1 ? i_ex1_data : (rs1_ex2 ? i_ex2_data : i_ra_data);
    assign rs2_val = rs2_ex1 ? i_ex1_data : (rs2_ex2 ? i_ex2_data : i_rb_data);
    assign rs1_stall = rs1_ex1 ? !i_ex1_data_valid : (rs1_ex2 && !i_ex2_data_valid);
    // rs2 is not read at all with an immediate operand
    assign rs2_stall = !hold_use_imm_q &&
                       (rs2_ex1 ? !i_ex1_data_valid : (rs2_ex2 && !i_ex2_data_valid));

    assign is_mul = hold_op_type_q == ex_pkg::OP_MUL;
    assign o_issue = hold_valid_q && !rs1_stall && !rs2_stall && i_ex1_ready &&
                     !(is_mul && !i_mul_ready);
    assign o_ready = !hold_valid_q || o_issue;

    ////////////////////
    // Execute and issue
    ////////////////////

    assign op_b = hold_use_imm_q ? hold_imm_q : rs2_val;

    alu u_alu (
        .i_op     (hold_alu_op_q),
        .i_a      (rs1_val),
        .i_b      (op_b),
        .o_result (o_issue_data)
    );

    assign o_mul_start = o_issue && is_mul;
    assign o_mul_a = rs1_val;
    assign o_mul_b = op_b;
    assign o_issue_unit = is_mul ? ex_pkg::FU_MUL : ex_pkg::FU_ALU;
    assign o_issue_rd = hold_rd_q;

endmodule

// File: src/result_stages.sv
`timescale 1ns/100ps
`include "ex_config.svh"

module result_stages (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Issue
    input  logic                  i_issue,
    input  ex_pkg::func_unit_e    i_issue_unit,
    input  logic [`EX_RIDX_W-1:0] i_issue_rd,
    input  logic [`EX_XLEN-1:0]   i_issue_data,
    // Multiplier
    input  logic                  i_mul_valid,
    input  logic [`EX_XLEN-1:0]   i_mul_product,
    // Bypass
    output logic                  o_ex1_pending,
    output logic [`EX_RIDX_W-1:0] o_ex1_rd,
    output logic                  o_ex1_data_valid,
    output logic [`EX_XLEN-1:0]   o_ex1_data,
    output logic                  o_ex2_pending,
    output logic [`EX_RIDX_W-1:0] o_ex2_rd,
    output logic                  o_ex2_data_valid,
    output logic [`EX_XLEN-1:0]   o_ex2_data,
    output logic                  o_ex1_ready,
    // Write-back
    output logic                  o_wb_valid,
    output logic [`EX_RIDX_W-1:0] o_wb_rd,
    output logic [`EX_XLEN-1:0]   o_wb_data
);

    logic                  ex1_pending_q, ex2_pending_q;
    ex_pkg::func_unit_e    ex1_unit_q, ex2_unit_q;
    logic [`EX_RIDX_W-1:0] ex1_rd_q, ex2_rd_q;
    logic [`EX_XLEN-1:0]   ex1_data_q, ex2_data_q;
    logic                  ex2_ready;
    logic                  ex1_advance;

    ////////////////////
    // Result select
    ////////////////////

    // A MUL in both stages means the product belongs to EX2
    assign o_ex1_data_valid = (ex1_unit_q == ex_pkg::FU_ALU) ||
                              (i_mul_valid && ex2_unit_q != ex_pkg::FU_MUL);
    assign o_ex1_data = (ex1_unit_q == ex_pkg::FU_ALU) ? ex1_data_q : i_mul_product;

    assign o_ex2_data_valid = (ex2_unit_q == ex_pkg::FU_ALU) || i_mul_valid;
    assign o_ex2_data = (ex2_unit_q == ex_pkg::FU_ALU) ? ex2_data_q : i_mul_product;

    assign ex2_ready = !ex2_pending_q || o_ex2_data_valid;
    assign ex1_advance = ex1_pending_q && ex2_ready;
    assign o_ex1_ready = ex2_ready || !ex1_pending_q;

    ////////////////////
    // Stage control
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex1_pending_q <= 1'b0;
            ex1_unit_q <= ex_pkg::FU_ALU;
            ex2_pending_q <= 1'b0;
            ex2_unit_q <= ex_pkg::FU_ALU;
        end else begin
            // Once the result is in, EX1 stops waiting on its unit
            if (o_ex1_data_valid || ex2_ready) begin
                ex1_unit_q <= ex_pkg::FU_ALU;
            end
            if (ex2_ready) begin
                ex1_pending_q <= 1'b0;
            end
            if (i_issue) begin
                ex1_pending_q <= 1'b1;
                ex1_unit_q <= i_issue_unit;
            end

            // EX2 empties on retire and refills from EX1
            if (o_ex2_data_valid) begin
                ex2_pending_q <= 1'b0;
                ex2_unit_q <= ex_pkg::FU_ALU;
            end
            if (ex1_advance) begin
                ex2_pending_q <= 1'b1;
                ex2_unit_q <= o_ex1_data_valid ? ex_pkg::FU_ALU : ex1_unit_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (o_ex1_data_valid) begin
            ex1_data_q <= o_ex1_data;
        end
        if (i_issue) begin
            ex1_rd_q <= i_issue_rd;
            ex1_data_q <= i_issue_data;
        end
        if (ex1_advance) begin
            ex2_rd_q <= ex1_rd_q;
            ex2_data_q <= o_ex1_data;
        end
    end

    assign o_ex1_pending = ex1_pending_q;
    assign o_ex1_rd = ex1_rd_q;
    assign o_ex2_pending = ex2_pending_q;
    assign o_ex2_rd = ex2_rd_q;

    // Retire from EX2 in program order
    assign o_wb_valid = ex2_pending_q && o_ex2_data_valid;
    assign o_wb_rd = ex2_rd_q;
    assign o_wb_data = o_ex2_data;

endmodule

// File: src/ex_core.sv
`timescale 1ns/100ps
`include "ex_config.svh"

module ex_core (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Decoded instruction in
    input  logic                  i_valid,
    output logic                  o_ready,
    input  ex_pkg::op_type_e      i_op_type,
    input  ex_pkg::alu_op_e       i_alu_op,
    input  logic [`EX_RIDX_W-1:0] i_rd,
    input  logic [`EX_RIDX_W-1:0] i_rs1,
    input  logic [`EX_RIDX_W-1:0] i_rs2,
    input  logic                  i_use_imm,
    input  logic [`EX_XLEN-1:0]   i_imm,
    // Retired instruction out
    output logic                  o_wb_valid,
    output logic [`EX_RIDX_W-1:0] o_wb_rd,
    output logic [`EX_XLEN-1:0]   o_wb_data
);

    logic [`EX_RIDX_W-1:0] ra_sel, rb_sel;
    logic [`EX_XLEN-1:0]   ra_data, rb_data;

    logic                  ex1_pending, ex1_data_valid, ex2_pending, ex2_data_valid;
    logic [`EX_RIDX_W-1:0] ex1_rd, ex2_rd;
    logic [`EX_XLEN-1:0]   ex1_data, ex2_data;
    logic                  ex1_ready;

    logic                  issue;
    ex_pkg::func_unit_e    issue_unit;
    logic [`EX_RIDX_W-1:0] issue_rd;
    logic [`EX_XLEN-1:0]   issue_data;

    logic                  mul_start, mul_ready, mul_valid;
    logic [`EX_XLEN-1:0]   mul_a, mul_b, mul_product;

    ////////////////////
    // Issue
    ////////////////////

    issue_stage u_issue (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .i_valid          (i_valid),
        .o_ready          (o_ready),
        .i_op_type        (i_op_type),
        .i_alu_op         (i_alu_op),
        .i_rd             (i_rd),
        .i_rs1            (i_rs1),
        .i_rs2            (i_rs2),
        .i_use_imm        (i_use_imm),
        .i_imm            (i_imm),
        .o_ra_sel         (ra_sel),
        .o_rb_sel         (rb_sel),
        .i_ra_data        (ra_data),
        .i_rb_data        (rb_data),
        .i_ex1_pending    (ex1_pending),
        .i_ex1_rd         (ex1_rd),
        .i_ex1_data_valid (ex1_data_valid),
        .i_ex1_data       (ex1_data),
        .i_ex2_pending    (ex2_pending),
        .i_ex2_rd         (ex2_rd),
        .i_ex2_data_valid (ex2_data_valid),
        .i_ex2_data       (ex2_data),
        .i_mul_ready      (mul_ready),
        .o_mul_start      (mul_start),
        .o_mul_a          (mul_a),
        .o_mul_b          (mul_b),
        .i_ex1_ready      (ex1_ready),
        .o_issue          (issue),
        .o_issue_unit     (issue_unit),
        .o_issue_rd       (issue_rd),
        .o_issue_data     (issue_data)
    );

    ////////////////////
    // EX1, EX2 and MUL
    ////////////////////

    result_stages u_result (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .i_issue          (issue),
        .i_issue_unit     (issue_unit),
        .i_issue_rd       (issue_rd),
        .i_issue_data     (issue_data),
        .i_mul_valid      (mul_valid),
        .i_mul_product    (mul_product),
        .o_ex1_pending    (ex1_pending),
        .o_ex1_rd         (ex1_rd),
        .o_ex1_data_valid (ex1_data_valid),
        .o_ex1_data       (ex1_data),
        .o_ex2_pending    (ex2_pending),
        .o_ex2_rd         (ex2_rd),
        .o_ex2_data_valid (ex2_data_valid),
        .o_ex2_data       (ex2_data),
        .o_ex1_ready      (ex1_ready),
        .o_wb_valid       (o_wb_valid),
        .o_wb_rd          (o_wb_rd),
        .o_wb_data        (o_wb_data)
    );

    mul_unit u_mul (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .i_start   (mul_start),
        .i_a       (mul_a),
        .i_b       (mul_b),
        .o_ready   (mul_ready),
        .o_valid   (mul_valid),
        .o_product (mul_product)
    );

    // Write port is fed straight from the retiring EX2 entry
    reg_file u_rf (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .i_ra_sel  (ra_sel),
        .i_rb_sel  (rb_sel),
        .o_ra_data (ra_data),
        .o_rb_data (rb_data),
        .i_w_en    (o_wb_valid),
        .i_w_sel   (o_wb_rd),
        .i_w_data  (o_wb_data)
    );

endmodule

// File: sim/tb_ex_core.sv
`timescale 1ns/100ps
`include "ex_config.svh"

module tb_ex_core;

    localparam int READY_TIMEOUT = 64;
    localparam int DRAIN_TIMEOUT = 400;
    localparam int RANDOM_COUNT = 300;

    logic                  clk_i = 1'b0;
    logic                  rst_ni;
    logic                  i_valid;
    logic                  o_ready;
    ex_pkg::op_type_e      i_op_type;
    ex_pkg::alu_op_e       i_alu_op;
    logic [`EX_RIDX_W-1:0] i_rd;
    logic [`EX_RIDX_W-1:0] i_rs1;
    logic [`EX_RIDX_W-1:0] i_rs2;
    logic                  i_use_imm;
    logic [`EX_XLEN-1:0]   i_imm;
    logic                  o_wb_valid;
    logic [`EX_RIDX_W-1:0] o_wb_rd;
    logic [`EX_XLEN-1:0]   o_wb_data;

    // Architectural state in program order, updated at transfer
    logic [`EX_XLEN-1:0]   model [`EX_NREGS];
    logic [`EX_RIDX_W-1:0] exp_rd_q [$];
    logic [`EX_XLEN-1:0]   exp_data_q [$];
    logic [31:0]           lfsr = 32'hd98e705f;
    string                 cur_test = "reset";
    bit                    timed_out = 1'b0;
    int                    errors = 0;
    int                    errors_at_start = 0;
    int                    checks = 0;
    int                    retired = 0;
    int                    tests = 0;

    ex_core uut (.*);

    always #4 clk_i = ~clk_i;

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [`EX_XLEN-1:0] expected_result(input ex_pkg::op_type_e t,
                                                            input ex_pkg::alu_op_e op,
                                                            input logic [`EX_XLEN-1:0] a,
                                                            input logic [`EX_XLEN-1:0] b);
        logic [2*`EX_XLEN-1:0] ext;
        ext = {{`EX_XLEN{a[`EX_XLEN-1]}}, a} >> b[4:0];
        if (t == ex_pkg::OP_MUL) begin
            return a * b;
        end
        case (op)
            ex_pkg::ADD:  return a + b;
            ex_pkg::SUB:  return a + ~b + 1;
            ex_pkg::AND:  return a & b;
            ex_pkg::OR:   return a | b;
            ex_pkg::XOR:  return a ^ b;
            // Flipping the sign bits turns a signed compare into an unsigned one
            ex_pkg::SLT:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ex_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
            ex_pkg::SLL:  return a << b[4:0];
            ex_pkg::SRL:  return a >> b[4:0];
            ex_pkg::SRA:  return ext[`EX_XLEN-1:0];
            default:      return '0;
        endcase
    endfunction

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    ////////////////////
    // Driver tasks
    ////////////////////

    task automatic note_timeout(input string what);
        $display("Timeout in %s while waiting for %s", cur_test, what);
        timed_out = 1'b1;
        errors++;
    endtask

    // Called a little after a rising edge, returns at the same point
    task automatic send_instr(input ex_pkg::op_type_e t, input ex_pkg::alu_op_e op,
                              input logic [`EX_RIDX_W-1:0] rd,
                              input logic [`EX_RIDX_W-1:0] rs1,
                              input logic [`EX_RIDX_W-1:0] rs2,
                              input logic use_imm, input logic [`EX_XLEN-1:0] imm);
        int                  cycles;
        logic [`EX_XLEN-1:0] a;
        logic [`EX_XLEN-1:0] b;
        logic [`EX_XLEN-1:0] res;
        if (timed_out) begin
            return;
        end
        i_valid = 1'b1;
        i_op_type = t;
        i_alu_op = op;
        i_rd = rd;
        i_rs1 = rs1;
        i_rs2 = rs2;
        i_use_imm = use_imm;
        i_imm = imm;
        cycles = 0;
        @(negedge clk_i);
        while (!o_ready && cycles < READY_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!o_ready) begin
            note_timeout("o_ready to accept an instruction");
            i_valid = 1'b0;
            return;
        end
        @(posedge clk_i);
        a = model[rs1];
        b = use_imm ? imm : model[rs2];
        res = expected_result(t, op, a, b);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(res);
        if (rd != '0) begin
            model[rd] = res;
        end
        #1;
        i_valid = 1'b0;
    endtask

    task automatic wait_retired();
        int cycles;
        if (timed_out) begin
            return;
        end
        cycles = 0;
        while (exp_rd_q.size() > 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (exp_rd_q.size() > 0) begin
            note_timeout("outstanding instructions to retire");
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("Test %s finished with %0d errors", cur_test, errors - errors_at_start);
    endtask

    ////////////////////
    // Retire checker
    ////////////////////

    always @(negedge clk_i) begin : retire_check
        logic [`EX_RIDX_W-1:0] exp_rd;
        logic [`EX_XLEN-1:0]   exp_data;
        if (rst_ni && o_wb_valid) begin
            retired++;
            checks++;
            assert (exp_rd_q.size() > 0) else begin
                $display("Write-back to x%0d in %s with no instruction outstanding",
                         o_wb_rd, cur_test);
                errors++;
            end
            if (exp_rd_q.size() > 0) begin
                exp_rd = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                assert (o_wb_rd == exp_rd) else begin
                    $display("FAIL %s: rd expected %0d actual %0d", cur_test, exp_rd, o_wb_rd);
                    errors++;
                end
                assert (o_wb_data == exp_data) else begin
                    $display("FAIL %s: x%0d expected 0x%08h actual 0x%08h",
                             cur_test, exp_rd, exp_data, o_wb_data);
                    errors++;
                end
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic run_tests();
        logic [31:0]           r;
        ex_pkg::op_type_e      t;
        ex_pkg::alu_op_e       op;
        logic [`EX_RIDX_W-1:0] rd;
        logic [`EX_RIDX_W-1:0] rs1;
        logic [`EX_RIDX_W-1:0] rs2;
        logic                  use_imm;
        logic [`EX_XLEN-1:0]   imm;
        int                    start_retired;
        for (int i = 0; i < `EX_NREGS; i++) begin
            model[i] = '0;
        end
        rst_ni = 1'b0;
        i_valid = 1'b0;
        i_op_type = ex_pkg::OP_ALU;
        i_alu_op = ex_pkg::ADD;
        i_rd = '0;
        i_rs1 = '0;
        i_rs2 = '0;
        i_use_imm = 1'b0;
        i_imm = '0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        start_test("reset");
        @(negedge clk_i);
        checks += 2;
        assert (!o_wb_valid) else begin
            $display("FAIL %s: o_wb_valid expected 0 actual %0b", cur_test, o_wb_valid);
            errors++;
        end
        assert (o_ready) else begin
            $display("FAIL %s: o_ready expected 1 actual %0b", cur_test, o_ready);
            errors++;
        end
        @(posedge clk_i);
        #1;
        end_test();

        // Register and immediate form of every opcode
        start_test("alu_ops");
        send_instr(ex_pkg::OP_ALU, ex_pkg::ADD, 5'd1, 5'd0, 5'd0, 1'b1, 32'h8000_0f0f);
        send_instr(ex_pkg::OP_ALU, ex_pkg::ADD, 5'd2, 5'd0, 5'd0, 1'b1, 32'h0000_0013);
        wait_retired();
        for (int k = 0; k < 10; k++) begin
            op = ex_pkg::alu_op_e'(4'(k));
            send_instr(ex_pkg::OP_ALU, op, 5'(10 + k), 5'd1, 5'd2, 1'b0, '0);
            send_instr(ex_pkg::OP_ALU, op, 5'(20 + k), 5'd1, 5'd0, 1'b1, 32'hffff_fff5);
        end
        send_instr(ex_pkg::OP_ALU, ex_pkg::ADD, 5'd0, 5'd1, 5'd2, 1'b0, '0);
        send_instr(ex_pkg::OP_ALU, ex_pkg::OR, 5'd3, 5'd0, 5'd0, 1'b1, 32'h0000_005a);
        send_instr(ex_pkg::OP_ALU, ex_pkg::ADD, 5'd4, 5'd0, 5'd0, 1'b0, '0);
        wait_retired();
        if (timed_out) begin
            return;
        end
        end_test();

        // Each instruction reads the one before it
        start_test("bypass_chain");
        send_instr(ex_pkg::OP_ALU, ex_pkg::ADD, 5'd5, 5'd0, 5'd0, 1'b1, 32'h0000_0003);
        rs1 = 5'd5;
        for (int i = 0; i < 16; i++) begin
            rd = 5'(6 + i % 4);
            rs2 = (i % 2 == 1) ? rs1 : 5'd1;
            send_instr(ex_pkg::OP_ALU, ex_pkg::alu_op_e'(4'(i % 10)), rd, rs1, rs2,
                       i % 3 == 0, 32'(i * 37 + 5));
            rs1 = rd;
        end
        wait_retired();
        if (timed_out) begin
            return;
        end
        end_test();

        start_test("multiplier");
        send_instr(ex_pkg::OP_ALU, ex_pkg::ADD, 5'd6, 5'd0, 5'd0, 1'b1, 32'h0000_0007);
        send_instr(ex_pkg::OP_ALU, ex_pkg::ADD, 5'd7, 5'd0, 5'd0, 1'b1, 32'hffff_ffff);
        send_instr(ex_pkg::OP_ALU, ex_pkg::ADD, 5'd8, 5'd0, 5'd0, 1'b1, 32'h1234_5678);
        send_instr(ex_pkg::OP_MUL, ex_pkg::ADD, 5'd9, 5'd6, 5'd0, 1'b1, 32'h0000_0003);
        send_instr(ex_pkg::OP_MUL, ex_pkg::ADD, 5'd10, 5'd8, 5'd0, 1'b0, '0);
        send_instr(ex_pkg::OP_MUL, ex_pkg::ADD, 5'd11, 5'd7, 5'd8, 1'b0, '0);
        send_instr(ex_pkg::OP_ALU, ex_pkg::ADD, 5'd12, 5'd11, 5'd0, 1'b1, 32'h0000_0001);
        send_instr(ex_pkg::OP_ALU, ex_pkg::SUB, 5'd13, 5'd12, 5'd11, 1'b0, '0);
        send_instr(ex_pkg::OP_MUL, ex_pkg::ADD, 5'd14, 5'd11, 5'd7, 1'b0, '0);
        send_instr(ex_pkg::OP_ALU, ex_pkg::XOR, 5'd15, 5'd14, 5'd9, 1'b0, '0);
        wait_retired();
        if (timed_out) begin
            return;
        end
        end_test();

        start_test("random_stream");
        start_retired = retired;
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            r = lfsr_bits(3);
            if (r[2:0] == 3'd0) begin
                @(posedge clk_i);
                #1;
            end
            r = lfsr_bits(2);
            t = (r[1:0] == 2'd0) ? ex_pkg::OP_MUL : ex_pkg::OP_ALU;
            r = lfsr_bits(4);
            op = ex_pkg::alu_op_e'(r[3:0] % 4'd10);
            r = lfsr_bits(5);
            rd = r[4:0];
            r = lfsr_bits(5);
            rs1 = r[4:0];
            r = lfsr_bits(5);
            rs2 = r[4:0];
            r = lfsr_bits(1);
            use_imm = r[0];
            imm = lfsr_bits(32);
            send_instr(t, op, rd, rs1, rs2, use_imm, imm);
        end
        wait_retired();
        if (timed_out) begin
            return;
        end
        checks++;
        assert (retired - start_retired == RANDOM_COUNT) else begin
            $display("FAIL %s: retired count expected %0d actual %0d",
                     cur_test, RANDOM_COUNT, retired - start_retired);
            errors++;
        end
        end_test();
    endtask

    initial begin
        run_tests();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+src
src/ex_pkg.sv
src/alu.sv
src/mul_unit.sv
src/reg_file.sv
src/issue_stage.sv
src/result_stages.sv
src/ex_core.sv
sim/tb_ex_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute back-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_ex_core \
    -Mdir obj_dir \
    -f src.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_ex_core)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The result is decided by the testbench's own summary line
if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
